// File: design/w5300_pkg.sv
`default_nettype none

package w5300_pkg;

	// host bus
	localparam int ADDR_W = 10;              // W5300 host address width
	localparam int BYTE_W = 8;               // bus and character width
	localparam int REG_W  = 16;              // W5300 register width

	// uart timing, a board build changes only this value
	localparam int CLKS_PER_BIT = 16;

	// clocks that cs_n and rd_n stay low in one byte cycle
	localparam int RD_STROBE_CYCLES = 4;

	// control characters
	localparam logic [BYTE_W-1:0] CH_CR = 8'h0d;
	localparam logic [BYTE_W-1:0] CH_LF = 8'h0a;

	// console commands
	localparam logic [BYTE_W-1:0] CMD_HELP     = 8'h68;   // h
	localparam logic [BYTE_W-1:0] CMD_SET_ADDR = 8'h61;   // a
	localparam logic [BYTE_W-1:0] CMD_READ_REG = 8'h62;   // b

	// message identifiers
	localparam logic [1:0] MSG_HELP = 2'd0;
	localparam logic [1:0] MSG_ADDR = 2'd1;
	localparam logic [1:0] MSG_READ = 2'd2;

	// line buffer depth in characters
	localparam int LINE_MAX = 12;

	// fixed message text, first character in the top byte
	localparam logic [13*BYTE_W-1:0] TXT_HELP = "a=addr b=read";
	localparam logic [5*BYTE_W-1:0]  TXT_ADDR = "addr:";
	localparam logic [5*BYTE_W-1:0]  TXT_DATA = "data:";

endpackage

`default_nettype wire

// File: design/uart_rx.sv
`default_nettype none

module uart_rx import w5300_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               rx_pin,
	output logic [BYTE_W-1:0] rx_data,
	output logic              rx_valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t                         state;
	logic [1:0]                        rx_sync;     // two flop synchroniser
	logic [$clog2(CLKS_PER_BIT)-1:0]   clk_cnt;
	logic [2:0]                        bit_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;                       // line idles high
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx_pin};
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_sync[1])
						state <= RX_START;
				end
				RX_START: begin
					if (clk_cnt == CLKS_PER_BIT / 2 - 1) begin   // middle of start bit
						clk_cnt <= '0;
						bit_cnt <= '0;
						state <= rx_sync[1] ? RX_IDLE : RX_DATA;  // glitch, not a start bit
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == CLKS_PER_BIT - 1) begin
						clk_cnt <= '0;
						rx_data <= {rx_sync[1], rx_data[BYTE_W-1:1]};   // lsb first
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (clk_cnt == CLKS_PER_BIT - 1) begin   // middle of stop bit
						rx_valid <= rx_sync[1];               // framing error drops the byte
						state <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`default_nettype none

module uart_tx import w5300_pkg::*; (
	input  wire              clk,
	input  wire              rst_n,
	input  wire [BYTE_W-1:0] tx_data,
	input  wire              tx_valid,
	output logic             tx_ready,
	output logic             tx_pin
);

	logic                              busy;
	logic [BYTE_W:0]                   frame;       // data bits then stop bit
	logic [$clog2(CLKS_PER_BIT)-1:0]   clk_cnt;
	logic [3:0]                        bit_idx;     // 0 is the start bit

	assign tx_ready = !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			tx_pin <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			clk_cnt <= '0;
			bit_idx <= '0;
			if (tx_valid) begin
				busy <= 1'b1;
				tx_pin <= 1'b0;                     // start bit
			end
		end else if (clk_cnt == CLKS_PER_BIT - 1) begin
			clk_cnt <= '0;
			if (bit_idx == 4'd9) begin
				busy <= 1'b0;                       // stop bit done
			end else begin
				tx_pin <= frame[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// payload shifter
	always_ff @(posedge clk) begin
		if (!busy && tx_valid)
			frame <= {1'b1, tx_data};
		else if (busy && clk_cnt == CLKS_PER_BIT - 1)
			frame <= {1'b1, frame[BYTE_W:1]};       // refill with stop level
	end

endmodule

`default_nettype wire

// File: design/console_text.sv
`default_nettype none

module console_text import w5300_pkg::*; (
	input  wire [1:0]         msg_id,
	input  wire [5:0]         msg_idx,
	input  wire [ADDR_W-1:0]  cur_addr,
	input  wire [REG_W-1:0]   reg_data,
	output logic [BYTE_W-1:0] text_byte,
	output logic              text_last
);

	logic [13*BYTE_W-1:0] help_shift;
	logic [5*BYTE_W-1:0]  addr_hdr_shift;
	logic [5*BYTE_W-1:0]  data_hdr_shift;
	logic [ADDR_W-1:0]    addr_shift;
	logic [REG_W-1:0]     data_shift;
	logic [5:0]           data_off;       // index relative to "data:"

	assign data_off = msg_idx - 6'd17;

	// wanted character or digit always ends up in the top position
	assign help_shift     = TXT_HELP << (BYTE_W * msg_idx);
	assign addr_hdr_shift = TXT_ADDR << (BYTE_W * msg_idx);
	assign data_hdr_shift = TXT_DATA << (BYTE_W * data_off);
	assign addr_shift     = cur_addr << (msg_idx - 6'd5);
	assign data_shift     = reg_data << (msg_idx - 6'd22);

	always_comb begin
		text_byte = CH_LF;
		text_last = 1'b0;
		case (msg_id)
			MSG_ADDR, MSG_READ: begin
				if (msg_idx < 6'd5)
					text_byte = addr_hdr_shift[5*BYTE_W-1 -: BYTE_W];
				else if (msg_idx < 6'd15)
					text_byte = {7'h18, addr_shift[ADDR_W-1]};   // "0" or "1"
				else if (msg_idx == 6'd15)
					text_byte = CH_CR;
				else if (msg_idx == 6'd16)
					text_last = (msg_id == MSG_ADDR);   // address message ends here
				else if (msg_idx < 6'd22)
					text_byte = data_hdr_shift[5*BYTE_W-1 -: BYTE_W];
				else if (msg_idx < 6'd38)
					text_byte = {7'h18, data_shift[REG_W-1]};
				else if (msg_idx == 6'd38)
					text_byte = CH_CR;
				else
					text_last = 1'b1;
			end
			default: begin
				// help line, also for the unused identifier
				if (msg_idx < 6'd13)
					text_byte = help_shift[13*BYTE_W-1 -: BYTE_W];
				else if (msg_idx == 6'd13)
					text_byte = CH_CR;
				else
					text_last = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/console_ctrl.sv
`default_nettype none

module console_ctrl import w5300_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire [BYTE_W-1:0]  rx_data,
	input  wire               rx_valid,
	output logic [BYTE_W-1:0] tx_data,
	output logic              tx_valid,
	input  wire               tx_ready,
	output logic [1:0]        msg_id,
	output logic [5:0]        msg_idx,
	input  wire [BYTE_W-1:0]  text_byte,
	input  wire               text_last,
	output logic [ADDR_W-1:0] cur_addr,
	output logic              rd_start,
	input  wire               rd_done,
	input  wire [REG_W-1:0]   rd_data,
	output logic [REG_W-1:0]  reg_data
);

	typedef enum logic [1:0] {C_IDLE, C_READ, C_SEND} ctrl_state_t;

	ctrl_state_t       state;
	logic [BYTE_W-1:0] line_buf [LINE_MAX];
	logic [3:0]        line_cnt;       // characters held, up to LINE_MAX
	logic              store_char;
	logic              line_end;
	logic [BYTE_W-1:0] line_cmd;
	logic [ADDR_W-1:0] addr_next;

	assign line_end   = (state == C_IDLE) && rx_valid && (rx_data == CH_CR);
	assign store_char = (state == C_IDLE) && rx_valid && (rx_data != CH_CR)
			&& (line_cnt < LINE_MAX);

	// an empty line behaves as a help request
	assign line_cmd = (line_cnt == '0) ? CMD_HELP : line_buf[0];

	assign tx_valid = (state == C_SEND);
	assign tx_data  = text_byte;

	// address digits are characters 1 to 10, msb first, lsb of each char taken
	always_comb begin
		addr_next = '0;
		for (int i = 0; i < ADDR_W; i++) begin
			if (i + 1 < line_cnt)
				addr_next[ADDR_W-1-i] = line_buf[i+1][0];
		end
	end

	always_ff @(posedge clk) begin
		if (store_char)
			line_buf[line_cnt] <= rx_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= C_IDLE;
			line_cnt <= '0;
			msg_id <= MSG_HELP;
			msg_idx <= '0;
			cur_addr <= '0;
			reg_data <= '0;
			rd_start <= 1'b0;
		end else begin
			rd_start <= 1'b0;
			case (state)
				C_IDLE: begin
					if (store_char)
						line_cnt <= line_cnt + 1'b1;
					if (line_end) begin
						line_cnt <= '0;
						msg_idx <= '0;
						case (line_cmd)
							CMD_SET_ADDR: begin
								cur_addr <= addr_next;
								msg_id <= MSG_ADDR;
								state <= C_SEND;
							end
							CMD_READ_REG: begin
								rd_start <= 1'b1;        // bus engine is idle here
								state <= C_READ;
							end
							default: begin
								msg_id <= MSG_HELP;
								state <= C_SEND;
							end
						endcase
					end
				end
				C_READ: begin
					if (rd_done) begin
						reg_data <= rd_data;
						msg_id <= MSG_READ;
						state <= C_SEND;
					end
				end
				default: begin
					if (tx_ready) begin                  // byte accepted this cycle
						if (text_last) begin
							msg_idx <= '0;
							state <= C_IDLE;
						end else begin
							msg_idx <= msg_idx + 6'd1;
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: design/w5300_bus.sv
`default_nettype none

module w5300_bus import w5300_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               rd_start,
	input  wire [ADDR_W-1:0]  reg_addr,
	output logic              rd_done,
	output logic [REG_W-1:0]  rd_data,
	output logic [ADDR_W-1:0] addr,
	output logic              cs_n,
	output logic              rd_n,
	input  wire [BYTE_W-1:0]  data_bus
);

	typedef enum logic [1:0] {B_IDLE, B_HI, B_GAP, B_LO} bus_state_t;

	bus_state_t                           state;
	logic                                 strobe;      // byte cycle active
	logic [$clog2(RD_STROBE_CYCLES)-1:0]  strobe_cnt;

	// read only bus, chip select and read strobe move together
	assign cs_n = !strobe;
	assign rd_n = !strobe;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= B_IDLE;
			strobe <= 1'b0;
			strobe_cnt <= '0;
			addr <= '0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			case (state)
				B_IDLE: begin
					if (rd_start) begin
						addr <= {reg_addr[ADDR_W-1:1], 1'b0};   // even byte first
						strobe <= 1'b1;
						strobe_cnt <= '0;
						state <= B_HI;
					end
				end
				B_GAP: begin
					addr[0] <= 1'b1;
					strobe <= 1'b1;
					strobe_cnt <= '0;
					state <= B_LO;
				end
				default: begin
					if (strobe_cnt == RD_STROBE_CYCLES - 1) begin
						strobe <= 1'b0;
						if (state == B_LO) begin
							rd_done <= 1'b1;
							state <= B_IDLE;          // the rd_done cycle is the idle gap
						end else begin
							state <= B_GAP;
						end
					end else begin
						strobe_cnt <= strobe_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// sample on the last strobe cycle
	always_ff @(posedge clk) begin
		if (strobe && strobe_cnt == RD_STROBE_CYCLES - 1) begin
			if (state == B_HI)
				rd_data[REG_W-1:BYTE_W] <= data_bus;
			else
				rd_data[BYTE_W-1:0] <= data_bus;
		end
	end

endmodule

`default_nettype wire

// File: design/w5300_console_top.sv
`default_nettype none

module w5300_console_top import w5300_pkg::*; (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               uart_rx,
	output logic              uart_tx,
	output logic [ADDR_W-1:0] addr,
	output logic              rd_n,
	output logic              cs_n,
	input  wire [BYTE_W-1:0]  data_bus
);

	logic [BYTE_W-1:0] rx_data;
	logic              rx_valid;
	logic [BYTE_W-1:0] tx_data;
	logic              tx_valid;
	logic              tx_ready;
	logic [1:0]        msg_id;
	logic [5:0]        msg_idx;
	logic [BYTE_W-1:0] text_byte;
	logic              text_last;
	logic [ADDR_W-1:0] cur_addr;
	logic [REG_W-1:0]  reg_data;
	logic              rd_start;
	logic              rd_done;
	logic [REG_W-1:0]  rd_data;

	uart_rx u_uart_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_pin   (uart_rx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	console_ctrl u_console_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.msg_id    (msg_id),
		.msg_idx   (msg_idx),
		.text_byte (text_byte),
		.text_last (text_last),
		.cur_addr  (cur_addr),
		.rd_start  (rd_start),
		.rd_done   (rd_done),
		.rd_data   (rd_data),
		.reg_data  (reg_data)
	);

	console_text u_console_text (
		.msg_id    (msg_id),
		.msg_idx   (msg_idx),
		.cur_addr  (cur_addr),
		.reg_data  (reg_data),
		.text_byte (text_byte),
		.text_last (text_last)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_data  (tx_data),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_pin   (uart_tx)
	);

	w5300_bus u_w5300_bus (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_start (rd_start),
		.reg_addr (cur_addr),
		.rd_done  (rd_done),
		.rd_data  (rd_data),
		.addr     (addr),
		.cs_n     (cs_n),
		.rd_n     (rd_n),
		.data_bus (data_bus)
	);

endmodule

`default_nettype wire

// File: test/w5300_bus_props.sv
`default_nettype none

module w5300_bus_props import w5300_pkg::*; (
	input wire clk,
	input wire rst_n,
	input wire rd_start,
	input wire rd_done,
	input wire cs_n,
	input wire rd_n
);

	assert property (@(posedge clk) disable iff (!rst_n) !rd_n |-> !cs_n)
		else $error("rd_n low while cs_n is high");

	// strobes stay low for one full byte cycle
	assert property (@(posedge clk) disable iff (!rst_n)
			$fell(cs_n) |-> !cs_n [*RD_STROBE_CYCLES] ##1 cs_n)
		else $error("cs_n low for the wrong number of cycles");

	assert property (@(posedge clk) disable iff (!rst_n)
			rd_start |=> !rd_start [*(2 * (RD_STROBE_CYCLES + 1) - 1)])
		else $error("rd_start while a register read is in progress");

	assert property (@(posedge clk) disable iff (!rst_n)
			rd_start |-> ##(2 * (RD_STROBE_CYCLES + 1)) rd_done)
		else $error("rd_done missing after rd_start");

	assert property (@(posedge clk) disable iff (!rst_n)
			rd_done |-> $past(rd_start, 2 * (RD_STROBE_CYCLES + 1)))
		else $error("rd_done without a matching rd_start");

endmodule

bind w5300_bus w5300_bus_props u_bus_props (
	.clk      (clk),
	.rst_n    (rst_n),
	.rd_start (rd_start),
	.rd_done  (rd_done),
	.cs_n     (cs_n),
	.rd_n     (rd_n)
);

`default_nettype wire

// File: test/tb_w5300_console.sv
`default_nettype none

module tb_w5300_console import w5300_pkg::*; ();

	logic              clk = 1'b0;
	logic              rst_n;
	logic              uart_rx;
	logic              uart_tx;
	logic [ADDR_W-1:0] addr;
	logic              rd_n;
	logic              cs_n;
	logic [BYTE_W-1:0] data_bus;

	string             vec_name [$];
	string             vec_cmd [$];
	logic [REG_W-1:0]  vec_val [$];        // address for a, register data for b
	logic [BYTE_W-1:0] rx_q [$];           // characters decoded from uart_tx
	logic [BYTE_W-1:0] mon_byte;
	logic [ADDR_W-1:0] exp_addr;           // register address the console should hold
	string             cur_name;
	int unsigned       cycle_cnt = 0;
	int unsigned       cycle_limit = 0;

	w5300_console_top UUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.uart_rx  (uart_rx),
		.uart_tx  (uart_tx),
		.addr     (addr),
		.rd_n     (rd_n),
		.cs_n     (cs_n),
		.data_bus (data_bus)
	);

	always #5 clk = ~clk;

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
			report_failure("Timeout: the response never completed");
	end

	// W5300 model, each byte reads back as its address xor a5
	always @(posedge clk) begin
		#1 data_bus = (!cs_n && !rd_n) ? (addr[7:0] ^ 8'ha5) : 8'h00;
	end

	// word address on the bus, the model only decodes the low byte
	always @(negedge clk) begin
		if (rst_n === 1'b1 && cs_n === 1'b0)
			assert (addr[ADDR_W-1:1] == exp_addr[ADDR_W-1:1]) else
				report_failure($sformatf("Fail %s: bus word address expected %h got %h",
					cur_name, exp_addr[ADDR_W-1:1], addr[ADDR_W-1:1]));
	end

	// serial monitor, samples at bit centres on the falling clock
	always begin
		@(negedge clk);
		if (rst_n === 1'b1 && uart_tx === 1'b0) begin
			repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
			for (int i = 0; i < BYTE_W; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				mon_byte[i] = uart_tx;              // lsb first
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			assert (uart_tx === 1'b1) else
				report_failure("Stop bit of a transmitted character was low");
			rx_q.push_back(mon_byte);
		end
	end

	task automatic send_char(input logic [BYTE_W-1:0] c);
		logic [9:0] frame;
		int         gap;
		frame = {1'b1, c, 1'b0};
		gap = $urandom % 4;                         // 0 to 3 idle bit times
		repeat (gap * CLKS_PER_BIT) @(posedge clk);
		for (int b = 0; b < 10; b++) begin
			@(posedge clk);
			#1 uart_rx = frame[b];
			repeat (CLKS_PER_BIT - 1) @(posedge clk);
		end
	endtask

	task automatic send_line(input string cmd);
		for (int i = 0; i < cmd.len(); i++)
			send_char(cmd[i]);
		send_char(CH_CR);
	endtask

	task automatic check_reply(input string name, input string want);
		logic [BYTE_W-1:0] got;
		for (int i = 0; i < want.len(); i++) begin
			while (rx_q.size() == 0)
				@(negedge clk);
			got = rx_q.pop_front();
			assert (got == want[i]) else
				report_failure($sformatf("Fail %s: byte %0d expected %h got %h",
					name, i, want[i], got));
		end
	endtask

	initial begin
		int                fd;
		int                n;
		string             line;
		string             name;
		string             cmd;
		string             want;
		logic [REG_W-1:0]  val;
		logic [BYTE_W-1:0] first;
		uart_rx = 1'b1;
		rst_n = 1'b0;
		data_bus = '0;
		exp_addr = '0;                              // address register after reset
		cur_name = "";
		void'($urandom(25));
		fd = $fopen("test/console_vectors.txt", "r");
		if (fd == 0)
			report_failure("Could not open test/console_vectors.txt");
		while ($fgets(line, fd) != 0) begin
			if (line[0] == "#")
				continue;
			val = '0;
			n = $sscanf(line, "%s %s %h", name, cmd, val);
			if (n < 2)
				continue;                           // blank line
			vec_name.push_back(name);
			vec_cmd.push_back(cmd == "-" ? "" : cmd);
			vec_val.push_back(n == 3 ? val : '0);
		end
		$fclose(fd);
		if (vec_cmd.size() == 0)
			report_failure("No vectors found in test/console_vectors.txt");
		cycle_limit = vec_cmd.size() * 60 * 10 * CLKS_PER_BIT * 2;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;
		foreach (vec_cmd[v]) begin
			cmd = vec_cmd[v];
			cur_name = vec_name[v];
			first = (cmd.len() > 0) ? cmd[0] : CMD_HELP;
			if (first == CMD_SET_ADDR) begin
				exp_addr = vec_val[v][ADDR_W-1:0];
				want = $sformatf("addr:%b%c%c", exp_addr, CH_CR, CH_LF);
			end else if (first == CMD_READ_REG) begin
				want = $sformatf("addr:%b%c%cdata:%b%c%c", exp_addr, CH_CR, CH_LF,
					vec_val[v], CH_CR, CH_LF);
			end else begin
				want = $sformatf("a=addr b=read%c%c", CH_CR, CH_LF);
			end
			send_line(cmd);
			check_reply(vec_name[v], want);
		end
		// nothing more may follow the last reply
		repeat (2 * 10 * CLKS_PER_BIT) @(negedge clk);
		assert (rx_q.size() == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			report_failure("Unexpected characters after the last response");
		end
	end

endmodule

`default_nettype wire

// File: test/console_vectors.txt
# columns: test name, command line ("-" is an empty line), expected value in hex
# expected value is the address for an a line, the register data for a b line, "-" for help
read_after_reset  b            a5a4
set_addr          a0110100101  1a5
read_set_addr     b            0100
unknown_command   x            -
empty_line        -            -
help_command      h            -
short_addr        a01          100
read_short_addr   b            a5a4
set_addr_max      a1111111111  3ff
read_addr_max     b            5b5a
set_addr_mixed    a1010101010  2aa
read_addr_mixed   b            0f0e
set_addr_low      a0000000011  003
read_addr_low     b            a7a6

// File: verilog.f
design/w5300_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/console_text.sv
design/console_ctrl.sv
design/w5300_bus.sv
design/w5300_console_top.sv
test/w5300_bus_props.sv
test/tb_w5300_console.sv
